/* rtl/lsq_defines.svh */
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// Entries per queue
`define LSQ_DEPTH 8
`define LSQ_IDX_W ($clog2(`LSQ_DEPTH))
// Queue pointer with wrap bit
`define LSQ_PTR_W ($clog2(`LSQ_DEPTH) + 1)

`define PREG_W 6
`define ROB_W 5

// External broadcast ports, plus the unit's own result
`define CDB_PORTS 2
`define CDB_ALL (`CDB_PORTS + 1)

`endif

/* rtl/lsq_pkg.sv */
`include "lsq_defines.svh"

package lsq_pkg;

    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_size_e;

    typedef struct packed {
        logic                   valid;
        logic [`PREG_W-1:0]     rs1_tag;
        logic [`PREG_W-1:0]     rs2_tag;
        logic [`PREG_W-1:0]     rd_tag;
        logic [`ROB_W-1:0]      rob_id;
        logic [31:0]            imm;
        mem_size_e              size;
        logic                   is_signed;
        logic                   rs1_ready;
        logic                   rs2_ready;
        // Other queue's tail when this entry was dispatched
        logic [`LSQ_PTR_W-1:0]  cross_ptr;
        logic                   order_met;
    } lsq_entry_t;

    typedef enum logic [2:0] {
        wait_load_p,
        wait_store_p,
        req_load,
        req_store,
        fin_load,
        fin_store
    } lsq_state_e;

endpackage

/* rtl/mem_queue.sv */
`timescale 1ns/1ps
`include "lsq_defines.svh"

module mem_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  push,
    input  lsq_pkg::lsq_entry_t   push_entry,
    input  logic                  pop,
    input  logic [`LSQ_DEPTH-1:0] upd_en,
    input  lsq_pkg::lsq_entry_t   upd_entry [`LSQ_DEPTH],
    output lsq_pkg::lsq_entry_t   entries [`LSQ_DEPTH],
    output logic [`LSQ_PTR_W-1:0] head_ptr,
    output logic [`LSQ_PTR_W-1:0] tail_ptr,
    output logic                  full
);

    logic [`LSQ_IDX_W-1:0] head_idx;
    logic [`LSQ_IDX_W-1:0] tail_idx;

    assign head_idx = head_ptr[`LSQ_IDX_W-1:0];
    assign tail_idx = tail_ptr[`LSQ_IDX_W-1:0];

    // Same slot, opposite lap
    assign full = (head_ptr[`LSQ_IDX_W] != tail_ptr[`LSQ_IDX_W]) && (head_idx == tail_idx);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                if (upd_en[i]) begin
                    entries[i] <= upd_entry[i];
                end
            end
            // Pop wins over a rewrite of the head slot
            if (pop) begin
                entries[head_idx].valid <= 1'b0;
                head_ptr <= head_ptr + `LSQ_PTR_W'(1);
            end
            if (push) begin
                entries[tail_idx] <= push_entry;
                tail_ptr <= tail_ptr + `LSQ_PTR_W'(1);
            end
        end
    end

endmodule

/* rtl/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic [1:0]         addr_low,
    input  lsq_pkg::mem_size_e size,
    input  logic               is_signed,
    input  logic [31:0]        store_data,
    input  logic [31:0]        rdata,
    output logic [3:0]         byte_mask,
    output logic [31:0]        wdata_shifted,
    output logic [31:0]        load_value
);

    logic [3:0]  size_mask;
    logic [31:0] rdata_low;

    always_comb begin
        case (size)
            lsq_pkg::mem_byte: size_mask = 4'b0001;
            lsq_pkg::mem_half: size_mask = 4'b0011;
            default:           size_mask = 4'b1111;
        endcase

        byte_mask = size_mask << addr_low;
        wdata_shifted = store_data << {addr_low, 3'b000};

        // Addressed bytes down to bit 0
        rdata_low = rdata >> {addr_low, 3'b000};

        case (size)
            lsq_pkg::mem_byte:
                load_value = {{24{is_signed & rdata_low[7]}}, rdata_low[7:0]};
            lsq_pkg::mem_half:
                load_value = {{16{is_signed & rdata_low[15]}}, rdata_low[15:0]};
            default:
                load_value = rdata_low;
        endcase
    end

endmodule

/* rtl/load_store_queue.sv */
`timescale 1ns/1ps
`include "lsq_defines.svh"

module load_store_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  logic                  is_store,
    input  lsq_pkg::mem_size_e    size,
    input  logic                  is_signed,
    input  logic [`PREG_W-1:0]    rs1_tag,
    input  logic [`PREG_W-1:0]    rs2_tag,
    input  logic [`PREG_W-1:0]    rd_tag,
    input  logic [`ROB_W-1:0]     rob_id,
    input  logic [31:0]           imm,
    input  logic                  rs1_ready,
    input  logic                  rs2_ready,
    output logic                  disp_stall,
    input  logic                  commit_store,
    input  logic [`CDB_ALL-1:0]   cdb_valid,
    input  logic [`PREG_W-1:0]    cdb_tag [`CDB_ALL],
    output logic [`PREG_W-1:0]    rf_rs1_tag,
    output logic [`PREG_W-1:0]    rf_rs2_tag,
    input  logic [31:0]           rf_rs1_value,
    input  logic [31:0]           rf_rs2_value,
    output logic [31:0]           dmem_addr,
    output logic [3:0]            dmem_rmask,
    output logic [3:0]            dmem_wmask,
    output logic [31:0]           dmem_wdata,
    input  logic [31:0]           dmem_rdata,
    input  logic                  dmem_resp,
    output logic                  lsq_cdb_valid,
    output logic [`PREG_W-1:0]    lsq_cdb_tag,
    output logic [31:0]           lsq_cdb_value,
    output logic [`ROB_W-1:0]     lsq_cdb_rob,
    output logic                  lsq_cdb_store
);

    lsq_pkg::lsq_entry_t load_entries [`LSQ_DEPTH];
    lsq_pkg::lsq_entry_t store_entries [`LSQ_DEPTH];
    lsq_pkg::lsq_entry_t load_upd [`LSQ_DEPTH];
    lsq_pkg::lsq_entry_t store_upd [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] load_upd_en;
    logic [`LSQ_DEPTH-1:0] store_upd_en;
    logic [`LSQ_PTR_W-1:0] load_head, load_tail, store_head, store_tail;
    logic load_full, store_full;

    lsq_pkg::lsq_entry_t new_entry, load_oldest, store_oldest, sel_entry, req_entry;
    logic push_load, push_store;
    logic load_ready, store_ready, in_wait, issue_load, issue_store;
    lsq_pkg::lsq_state_e state, next_state;

    logic [31:0] eff_addr, issue_wdata, load_value;
    logic [3:0]  issue_mask;
    logic [31:0] req_addr, req_wdata, res_value;
    logic [3:0]  req_mask;
    logic [1:0]  req_offset;

    // Source wakeup from the broadcasts and cross-queue ordering check
    function automatic lsq_pkg::lsq_entry_t wake(lsq_pkg::lsq_entry_t e,
                                                 logic [`LSQ_PTR_W-1:0] other_head);
        lsq_pkg::lsq_entry_t r;
        r = e;
        for (int p = 0; p < `CDB_ALL; p++) begin
            if (cdb_valid[p] && cdb_tag[p] == e.rs1_tag) begin
                r.rs1_ready = 1'b1;
            end
            if (cdb_valid[p] && cdb_tag[p] == e.rs2_tag) begin
                r.rs2_ready = 1'b1;
            end
        end
        if (e.cross_ptr == other_head) begin
            r.order_met = 1'b1;
        end
        return r;
    endfunction

    assign disp_stall = disp_valid && (is_store ? store_full : load_full);
    assign push_load  = disp_valid && !is_store && !load_full;
    assign push_store = disp_valid && is_store && !store_full;

    always_comb begin
        lsq_pkg::lsq_entry_t raw;
        raw.valid     = 1'b1;
        raw.rs1_tag   = rs1_tag;
        raw.rs2_tag   = rs2_tag;
        raw.rd_tag    = rd_tag;
        raw.rob_id    = rob_id;
        raw.imm       = imm;
        raw.size      = size;
        raw.is_signed = is_signed;
        raw.rs1_ready = rs1_ready || (rs1_tag == '0);
        raw.rs2_ready = rs2_ready || (rs2_tag == '0);
        raw.cross_ptr = is_store ? load_tail : store_tail;
        raw.order_met = 1'b0;
        // A broadcast in the dispatch cycle must not be missed
        new_entry = wake(raw, is_store ? load_head : store_head);
    end

    always_comb begin
        for (int d = 0; d < `LSQ_DEPTH; d++) begin
            load_upd[d]     = wake(load_entries[d], store_head);
            store_upd[d]    = wake(store_entries[d], load_head);
            load_upd_en[d]  = load_entries[d].valid;
            store_upd_en[d] = store_entries[d].valid;
        end
    end

    mem_queue load_q (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push_load),
        .push_entry (new_entry),
        .pop        (issue_load),
        .upd_en     (load_upd_en),
        .upd_entry  (load_upd),
        .entries    (load_entries),
        .head_ptr   (load_head),
        .tail_ptr   (load_tail),
        .full       (load_full)
    );

    mem_queue store_q (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push_store),
        .push_entry (new_entry),
        .pop        (issue_store),
        .upd_en     (store_upd_en),
        .upd_entry  (store_upd),
        .entries    (store_entries),
        .head_ptr   (store_head),
        .tail_ptr   (store_tail),
        .full       (store_full)
    );

    assign load_oldest  = load_entries[load_head[`LSQ_IDX_W-1:0]];
    assign store_oldest = store_entries[store_head[`LSQ_IDX_W-1:0]];

    assign load_ready = load_oldest.valid && load_oldest.rs1_ready
                        && load_oldest.rs2_ready && load_oldest.order_met;
    assign store_ready = store_oldest.valid && store_oldest.rs1_ready
                         && store_oldest.rs2_ready && store_oldest.order_met && commit_store;

    // Wait state picks the winner when both are ready
    assign in_wait = (state == lsq_pkg::wait_load_p) || (state == lsq_pkg::wait_store_p);
    assign issue_load = in_wait && load_ready
                        && (state == lsq_pkg::wait_load_p || !store_ready);
    assign issue_store = in_wait && store_ready && !issue_load;

    assign sel_entry  = issue_store ? store_oldest : load_oldest;
    assign rf_rs1_tag = sel_entry.rs1_tag;
    assign rf_rs2_tag = sel_entry.rs2_tag;
    assign eff_addr   = rf_rs1_value + sel_entry.imm;

    load_align issue_align (
        .addr_low      (eff_addr[1:0]),
        .size          (sel_entry.size),
        .is_signed     (sel_entry.is_signed),
        .store_data    (rf_rs2_value),
        .rdata         (32'b0),
        .byte_mask     (issue_mask),
        .wdata_shifted (issue_wdata),
        .load_value    ()
    );

    load_align resp_align (
        .addr_low      (req_offset),
        .size          (req_entry.size),
        .is_signed     (req_entry.is_signed),
        .store_data    (32'b0),
        .rdata         (dmem_rdata),
        .byte_mask     (),
        .wdata_shifted (),
        .load_value    (load_value)
    );

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= lsq_pkg::wait_load_p;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lsq_pkg::wait_load_p, lsq_pkg::wait_store_p: begin
                if (issue_load) begin
                    next_state = lsq_pkg::req_load;
                end else if (issue_store) begin
                    next_state = lsq_pkg::req_store;
                end
            end
            lsq_pkg::req_load:  if (dmem_resp) next_state = lsq_pkg::fin_load;
            lsq_pkg::req_store: if (dmem_resp) next_state = lsq_pkg::fin_store;
            // Hand priority to the other kind
            lsq_pkg::fin_load:  next_state = lsq_pkg::wait_store_p;
            lsq_pkg::fin_store: next_state = lsq_pkg::wait_load_p;
            default:            next_state = lsq_pkg::wait_load_p;
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue_load || issue_store) begin
            req_entry  <= sel_entry;
            req_addr   <= {eff_addr[31:2], 2'b00};
            req_offset <= eff_addr[1:0];
            req_mask   <= issue_mask;
            req_wdata  <= issue_wdata;
        end
        if (state == lsq_pkg::req_load && dmem_resp) begin
            res_value <= load_value;
        end
    end

    assign dmem_addr  = req_addr;
    assign dmem_rmask = (state == lsq_pkg::req_load) ? req_mask : 4'b0;
    assign dmem_wmask = (state == lsq_pkg::req_store) ? req_mask : 4'b0;
    assign dmem_wdata = (state == lsq_pkg::req_store) ? req_wdata : 32'b0;

    assign lsq_cdb_valid = (state == lsq_pkg::fin_load) || (state == lsq_pkg::fin_store);
    assign lsq_cdb_store = (state == lsq_pkg::fin_store);
    assign lsq_cdb_tag   = (state == lsq_pkg::fin_load) ? req_entry.rd_tag : '0;
    assign lsq_cdb_value = (state == lsq_pkg::fin_load) ? res_value : 32'b0;
    assign lsq_cdb_rob   = req_entry.rob_id;

endmodule

/* rtl/phys_regfile.sv */
`timescale 1ns/1ps
`include "lsq_defines.svh"

module phys_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic [`PREG_W-1:0]  rs1_tag,
    input  logic [`PREG_W-1:0]  rs2_tag,
    output logic [31:0]         rs1_value,
    output logic [31:0]         rs2_value,
    input  logic [`CDB_ALL-1:0] wr_en,
    input  logic [`PREG_W-1:0]  wr_tag [`CDB_ALL],
    input  logic [31:0]         wr_value [`CDB_ALL]
);

    logic [31:0] regs [2**`PREG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`PREG_W; i++) begin
                regs[i] <= 32'b0;
            end
        end else begin
            for (int p = 0; p < `CDB_ALL; p++) begin
                // Tag 0 is hardwired zero
                if (wr_en[p] && wr_tag[p] != '0) begin
                    regs[wr_tag[p]] <= wr_value[p];
                end
            end
        end
    end

    assign rs1_value = (rs1_tag == '0) ? 32'b0 : regs[rs1_tag];
    assign rs2_value = (rs2_tag == '0) ? 32'b0 : regs[rs2_tag];

endmodule

/* rtl/lsq_top.sv */
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  logic                  is_store,
    input  lsq_pkg::mem_size_e    size,
    input  logic                  is_signed,
    input  logic [`PREG_W-1:0]    rs1_tag,
    input  logic [`PREG_W-1:0]    rs2_tag,
    input  logic [`PREG_W-1:0]    rd_tag,
    input  logic [`ROB_W-1:0]     rob_id,
    input  logic [31:0]           imm,
    input  logic                  rs1_ready,
    input  logic                  rs2_ready,
    output logic                  disp_stall,
    input  logic [`CDB_PORTS-1:0] ext_cdb_valid,
    input  logic [`PREG_W-1:0]    ext_cdb_tag [`CDB_PORTS],
    input  logic [31:0]           ext_cdb_value [`CDB_PORTS],
    input  logic                  commit_store,
    output logic [31:0]           dmem_addr,
    output logic [3:0]            dmem_rmask,
    output logic [3:0]            dmem_wmask,
    output logic [31:0]           dmem_wdata,
    input  logic [31:0]           dmem_rdata,
    input  logic                  dmem_resp,
    output logic                  lsq_cdb_valid,
    output logic [`PREG_W-1:0]    lsq_cdb_tag,
    output logic [31:0]           lsq_cdb_value,
    output logic [`ROB_W-1:0]     lsq_cdb_rob,
    output logic                  lsq_cdb_store
);

    logic [`CDB_ALL-1:0] cdb_valid;
    logic [`PREG_W-1:0]  cdb_tag [`CDB_ALL];
    logic [31:0]         cdb_value [`CDB_ALL];
    logic [`PREG_W-1:0]  rf_rs1_tag, rf_rs2_tag;
    logic [31:0]         rf_rs1_value, rf_rs2_value;

    // Own result rides on the last port
    always_comb begin
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb_tag[p]   = ext_cdb_tag[p];
            cdb_value[p] = ext_cdb_value[p];
        end
        cdb_valid            = {lsq_cdb_valid, ext_cdb_valid};
        cdb_tag[`CDB_PORTS]   = lsq_cdb_tag;
        cdb_value[`CDB_PORTS] = lsq_cdb_value;
    end

    load_store_queue lsq_i (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .disp_valid    (disp_valid),
        .is_store      (is_store),
        .size          (size),
        .is_signed     (is_signed),
        .rs1_tag       (rs1_tag),
        .rs2_tag       (rs2_tag),
        .rd_tag        (rd_tag),
        .rob_id        (rob_id),
        .imm           (imm),
        .rs1_ready     (rs1_ready),
        .rs2_ready     (rs2_ready),
        .disp_stall    (disp_stall),
        .commit_store  (commit_store),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .rf_rs1_tag    (rf_rs1_tag),
        .rf_rs2_tag    (rf_rs2_tag),
        .rf_rs1_value  (rf_rs1_value),
        .rf_rs2_value  (rf_rs2_value),
        .dmem_addr     (dmem_addr),
        .dmem_rmask    (dmem_rmask),
        .dmem_wmask    (dmem_wmask),
        .dmem_wdata    (dmem_wdata),
        .dmem_rdata    (dmem_rdata),
        .dmem_resp     (dmem_resp),
        .lsq_cdb_valid (lsq_cdb_valid),
        .lsq_cdb_tag   (lsq_cdb_tag),
        .lsq_cdb_value (lsq_cdb_value),
        .lsq_cdb_rob   (lsq_cdb_rob),
        .lsq_cdb_store (lsq_cdb_store)
    );

    phys_regfile prf_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_tag   (rf_rs1_tag),
        .rs2_tag   (rf_rs2_tag),
        .rs1_value (rf_rs1_value),
        .rs2_value (rf_rs2_value),
        .wr_en     (cdb_valid),
        .wr_tag    (cdb_tag),
        .wr_value  (cdb_value)
    );

endmodule

/* sim/lsq_tb.sv */
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_tb;

    typedef struct packed {
        logic                is_store;
        lsq_pkg::mem_size_e  size;
        logic                is_signed;
        logic [31:0]         addr;
        logic [`PREG_W-1:0]  rs1_tag;
        logic [31:0]         rs1_val;
        logic                rs1_pend;
        logic [`PREG_W-1:0]  rs2_tag;
        logic [31:0]         rs2_val;
        logic                rs2_pend;
        logic [`PREG_W-1:0]  rd_tag;
        logic [`ROB_W-1:0]   rob;
    } op_t;

    typedef struct packed {
        logic [`PREG_W-1:0] tag;
        logic [31:0]        value;
        logic [`ROB_W-1:0]  rob;
        logic               store;
    } res_t;

    typedef struct packed {
        logic [`PREG_W-1:0] tag;
        logic [31:0]        value;
    } bcast_t;

    logic clk = 1'b0;
    logic rst, flush, disp_valid, is_store, is_signed, rs1_ready, rs2_ready;
    lsq_pkg::mem_size_e size;
    logic [`PREG_W-1:0] rs1_tag, rs2_tag, rd_tag;
    logic [`ROB_W-1:0] rob_id;
    logic [31:0] imm;
    logic disp_stall, commit_store;
    logic [`CDB_PORTS-1:0] ext_cdb_valid;
    logic [`PREG_W-1:0] ext_cdb_tag [`CDB_PORTS];
    logic [31:0] ext_cdb_value [`CDB_PORTS];
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata, lsq_cdb_value;
    logic [3:0] dmem_rmask, dmem_wmask;
    logic dmem_resp, lsq_cdb_valid, lsq_cdb_store;
    logic [`PREG_W-1:0] lsq_cdb_tag;
    logic [`ROB_W-1:0] lsq_cdb_rob;

    logic [31:0] stim_lfsr = 32'h4f6b89d3;
    logic [31:0] env_lfsr = 32'h4f6b89d3;
    logic [31:0] mem [64];
    // Reference memory, updated in program order
    logic [31:0] ref_mem [64];
    logic [31:0] regval [32];
    logic produced [64];
    op_t exp_q [$];
    res_t res_q [$];
    bcast_t bcast_q [$];
    logic hold_commit = 1'b1;
    logic prev_active = 1'b0;
    logic commit_prev = 1'b0;
    logic resp_busy = 1'b0;
    logic [1:0] resp_cnt;
    int pend_next = 16;
    int dispatched = 0;
    int completed = 0;
    int err_count = 0;
    logic [4:0] rd_ctr = '0;
    logic [`ROB_W-1:0] rob_ctr = '0;

    lsq_top lsq_top_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] stim_rand(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] env_rand(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            env_lfsr = lfsr_step(env_lfsr);
            r = {r[30:0], env_lfsr[0]};
        end
        return r;
    endfunction

    // Expected byte lanes and extended load value
    function automatic logic [3:0] lane_mask(input lsq_pkg::mem_size_e sz, input logic [1:0] off);
        logic [3:0] m;
        m = (sz == lsq_pkg::mem_byte) ? 4'h1 : (sz == lsq_pkg::mem_half) ? 4'h3 : 4'hf;
        return m << off;
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] off,
                                                input lsq_pkg::mem_size_e sz, input logic sgn);
        logic [31:0] w;
        w = word >> (8 * off);
        if (sz == lsq_pkg::mem_byte) begin
            return sgn ? {{24{w[7]}}, w[7:0]} : {24'b0, w[7:0]};
        end else if (sz == lsq_pkg::mem_half) begin
            return sgn ? {{16{w[15]}}, w[15:0]} : {16'b0, w[15:0]};
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        err_count++;
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_request(input logic [31:0] addr, input logic [3:0] rmask,
                                 input logic [3:0] wmask, input logic [31:0] wdata, input op_t e);
        logic [3:0] m;
        m = lane_mask(e.size, e.addr[1:0]);
        compare_word("dmem_addr", addr, {e.addr[31:2], 2'b00});
        compare_word("dmem_rmask", {28'b0, rmask}, e.is_store ? 32'h0 : {28'b0, m});
        compare_word("dmem_wmask", {28'b0, wmask}, e.is_store ? {28'b0, m} : 32'h0);
        compare_word("dmem_wdata", wdata, e.is_store ? e.rs2_val << (8 * e.addr[1:0]) : 32'h0);
    endtask

    task automatic check_result(input logic [`PREG_W-1:0] tag, input logic [31:0] value,
                                input logic [`ROB_W-1:0] rob, input logic store, input res_t e);
        compare_word("lsq_cdb_tag", 32'(tag), 32'(e.tag));
        compare_word("lsq_cdb_value", value, e.value);
        compare_word("lsq_cdb_rob", 32'(rob), 32'(e.rob));
        compare_word("lsq_cdb_store", 32'(store), 32'(e.store));
    endtask

    // Model store into the reference memory
    task automatic apply_store(input op_t o);
        logic [3:0] m;
        logic [31:0] d;
        m = lane_mask(o.size, o.addr[1:0]);
        d = o.rs2_val << (8 * o.addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (m[i]) begin
                ref_mem[o.addr[7:2]][8*i +: 8] = d[8*i +: 8];
            end
        end
    endtask

    // Broadcasts, commit level and the memory responder
    always @(posedge clk) begin
        bcast_t b;
        #1;
        ext_cdb_valid = '0;
        if (dmem_resp) begin
            dmem_resp = 1'b0;
        end else if (!rst) begin
            if (!resp_busy && (dmem_rmask != 0 || dmem_wmask != 0)) begin
                resp_busy = 1'b1;
                resp_cnt = 2'(env_rand(2));
            end
            if (resp_busy) begin
                if (resp_cnt == 0) begin
                    resp_busy = 1'b0;
                    dmem_resp = 1'b1;
                    dmem_rdata = mem[dmem_addr[7:2]];
                    for (int i = 0; i < 4; i++) begin
                        if (dmem_wmask[i]) mem[dmem_addr[7:2]][8*i +: 8] = dmem_wdata[8*i +: 8];
                    end
                end else begin
                    resp_cnt--;
                end
            end
        end
        if (!rst) begin
            for (int p = 0; p < `CDB_PORTS; p++) begin
                if (bcast_q.size() > 0 && env_rand(1)) begin
                    b = bcast_q.pop_front();
                    ext_cdb_valid[p] = 1'b1;
                    ext_cdb_tag[p] = b.tag;
                    ext_cdb_value[p] = b.value;
                    produced[b.tag] = 1'b1;
                end
            end
            commit_store = hold_commit ? 1'b0 : (env_rand(2) != 0);
        end
    end

    always @(negedge clk) begin
        op_t o;
        res_t r;
        logic active;
        if (!rst) begin
            active = (dmem_rmask != 0) || (dmem_wmask != 0);
            if (active && !prev_active) begin
                if (exp_q.size() == 0) abort_run("memory request with no operation pending");
                o = exp_q.pop_front();
                if ((o.rs1_pend && !produced[o.rs1_tag]) || (o.rs2_pend && !produced[o.rs2_tag]))
                    abort_run("operation issued before its source was broadcast");
                if (o.is_store && !commit_prev) abort_run("store issued while commit was low");
                check_request(dmem_addr, dmem_rmask, dmem_wmask, dmem_wdata, o);
                r.tag = o.rd_tag;
                r.rob = o.rob;
                r.store = o.is_store;
                r.value = o.is_store ? 32'h0 :
                          extend_load(ref_mem[o.addr[7:2]], o.addr[1:0], o.size, o.is_signed);
                res_q.push_back(r);
                if (o.is_store) begin
                    apply_store(o);
                end
            end
            if (lsq_cdb_valid) begin
                if (res_q.size() == 0) abort_run("result broadcast with no request completed");
                r = res_q.pop_front();
                check_result(lsq_cdb_tag, lsq_cdb_value, lsq_cdb_rob, lsq_cdb_store, r);
                completed++;
            end
            prev_active = active;
            commit_prev = commit_store;
        end
    end

    task automatic pick_source(input logic allow, output logic [`PREG_W-1:0] tag,
                               output logic [31:0] val, output logic pend);
        if (allow && pend_next < 32 && stim_rand(2) == 0) begin
            tag = pend_next[`PREG_W-1:0];
            val = stim_rand(32);
            pend = 1'b1;
            pend_next++;
        end else begin
            tag = `PREG_W'(1 + stim_rand(4) % 15);
            val = regval[tag];
            pend = 1'b0;
        end
    endtask

    task automatic dispatch(input op_t o, input logic keep, input logic expect_stall);
        int waited;
        logic accepted;
        @(posedge clk);
        #1;
        disp_valid = 1'b1;
        is_store = o.is_store;
        size = o.size;
        is_signed = o.is_signed;
        rs1_tag = o.rs1_tag;
        rs2_tag = o.rs2_tag;
        rd_tag = o.rd_tag;
        rob_id = o.rob;
        imm = o.addr - o.rs1_val;
        rs1_ready = !o.rs1_pend;
        rs2_ready = !o.rs2_pend;
        waited = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (expect_stall && waited == 0) begin
                if (!disp_stall) abort_run("full store queue did not raise disp_stall");
                hold_commit = 1'b0;
            end
            accepted = !disp_stall;
            waited++;
            if (waited > 500) abort_run("dispatch was never accepted");
        end
        if (o.rs1_pend) bcast_q.push_back({o.rs1_tag, o.rs1_val});
        if (o.rs2_pend) bcast_q.push_back({o.rs2_tag, o.rs2_val});
        if (keep) begin
            exp_q.push_back(o);
            dispatched++;
        end
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    // kind 0 random, 1 store, 2 load
    task automatic send_op(input int kind, input logic keep, input logic allow_pend,
                           input logic expect_stall);
        op_t o;
        logic [1:0] sel;
        logic [1:0] off;
        o.is_store = (kind == 1) ? 1'b1 : (kind == 2) ? 1'b0 : 1'(stim_rand(1));
        sel = 2'(stim_rand(2));
        o.size = (sel == 0) ? lsq_pkg::mem_byte : (sel == 1) ? lsq_pkg::mem_half : lsq_pkg::mem_word;
        off = (o.size == lsq_pkg::mem_byte) ? 2'(stim_rand(2)) :
              (o.size == lsq_pkg::mem_half) ? {1'(stim_rand(1)), 1'b0} : 2'b00;
        o.addr = {24'b0, 6'(stim_rand(6)), off};
        o.is_signed = o.is_store ? 1'b0 : 1'(stim_rand(1));
        pick_source(allow_pend, o.rs1_tag, o.rs1_val, o.rs1_pend);
        if (o.is_store) begin
            pick_source(allow_pend, o.rs2_tag, o.rs2_val, o.rs2_pend);
            o.rd_tag = '0;
        end else begin
            o.rs2_tag = '0;
            o.rs2_val = '0;
            o.rs2_pend = 1'b0;
            o.rd_tag = {1'b1, rd_ctr};
            rd_ctr++;
        end
        o.rob = rob_ctr;
        rob_ctr++;
        dispatch(o, keep, expect_stall);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || res_q.size() != 0 || bcast_q.size() != 0
               || completed != dispatched) begin
            @(negedge clk);
            waited++;
            if (waited > 3000) abort_run("queued operations did not complete");
        end
        @(posedge clk);
    endtask

    task automatic start_round();
        pend_next = 16;
        for (int t = 16; t < 32; t++) produced[t] = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        disp_valid = 1'b0;
        is_store = 1'b0;
        size = lsq_pkg::mem_word;
        is_signed = 1'b0;
        rs1_tag = '0;
        rs2_tag = '0;
        rd_tag = '0;
        rob_id = '0;
        imm = '0;
        rs1_ready = 1'b0;
        rs2_ready = 1'b0;
        commit_store = 1'b0;
        ext_cdb_valid = '0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            ext_cdb_tag[p] = '0;
            ext_cdb_value[p] = '0;
        end
        dmem_rdata = '0;
        dmem_resp = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {4{2'b10, i[5:0]}} ^ (i * 32'h9e3779b1);
            ref_mem[i] = mem[i];
        end
        for (int t = 0; t < 64; t++) produced[t] = 1'b0;
        regval[0] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        hold_commit = 1'b0;

        // Stable source registers
        for (int t = 1; t < 16; t++) begin
            regval[t] = stim_rand(32);
            bcast_q.push_back({`PREG_W'(t), regval[t]});
        end
        wait_drain();

        for (int r = 0; r < 12; r++) begin
            start_round();
            for (int i = 0; i < 12; i++) send_op(0, 1'b1, 1'b1, 1'b0);
            wait_drain();
        end

        // Fill the store queue while commit is held low
        hold_commit = 1'b1;
        start_round();
        for (int i = 0; i < `LSQ_DEPTH; i++) send_op(1, 1'b1, 1'b1, 1'b0);
        send_op(1, 1'b1, 1'b0, 1'b1);
        for (int i = 0; i < 4; i++) send_op(2, 1'b1, 1'b1, 1'b0);
        wait_drain();

        // Flush while the controller idles on uncommitted stores
        hold_commit = 1'b1;
        start_round();
        for (int i = 0; i < 3; i++) send_op(1, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 2; i++) send_op(2, 1'b0, 1'b0, 1'b0);
        repeat (6) @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        hold_commit = 1'b0;
        repeat (10) @(posedge clk);
        for (int i = 0; i < 12; i++) send_op(0, 1'b1, 1'b1, 1'b0);
        wait_drain();

        if (err_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/lsq_pkg.sv
rtl/mem_queue.sv
rtl/load_align.sv
rtl/load_store_queue.sv
rtl/phys_regfile.sv
rtl/lsq_top.sv
sim/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsq_pkg.sv
      - rtl/mem_queue.sv
      - rtl/load_align.sv
      - rtl/load_store_queue.sv
      - rtl/phys_regfile.sv
      - rtl/lsq_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/lsq_tb.sv
